// ==== include/pgwr_consts.svh ====
// page-table write manager constants
// table sizes, base addresses and line geometry
`ifndef PGWR_CONSTS_SVH
`define PGWR_CONSTS_SVH

// table sizes in entries
`define PGWR_ATT_ENTRY_CNT   16
`define PGWR_LIST_ENTRY_CNT  8

// byte address of the ATT table
`define PGWR_ATT_BASE        64'h0000_0000_0000_1000
// byte address of the list table
`define PGWR_LIST_BASE       64'h0000_0000_0000_2000

// page number handed to list entry 1
`define PGWR_PPA_BASE        50'h80

// line geometry
`define PGWR_LINE_BYTES      64
`define PGWR_ATT_PER_LINE    8    // 8-byte ATT entries
`define PGWR_LST_PER_LINE    4    // 16-byte list entries

// list pointer width, 0 is the null pointer
`define PGWR_PTR_W           32

`endif

// ==== src/pgwr_tbl_pkg.sv ====
// table types for the page-table write manager
// ATT and list entries, list pointers, head/tail record, update request
`default_nettype none
`include "pgwr_consts.svh"

package pgwr_tbl_pkg;

	typedef logic [`PGWR_PTR_W-1:0] lst_ptr_t;  // list entry id, 0 is null
	typedef logic [31:0] att_id_t;              // ATT entry id
	typedef logic [49:0] way_t;                 // page way

	typedef enum logic [1:0] {
		STS_DALLOC = 2'd0,
		STS_UNCOMP = 2'd1,
		STS_COMP   = 2'd2
	} att_sts_e;

	// 64-bit ATT entry, status in the low bits
	typedef struct packed {
		logic [11:0] count;  // zero-page count
		way_t        way;
		att_sts_e    sts;
	} att_entry_t;

	// 128-bit list entry, next in the low word
	typedef struct packed {
		logic [13:0] rsvd;
		way_t        way;
		lst_ptr_t    prev;
		lst_ptr_t    next;
	} lst_entry_t;

	typedef enum logic {
		LST_FREE   = 1'b0,
		LST_UNCOMP = 1'b1
	} list_sel_e;

	typedef struct packed {
		lst_ptr_t free_head;
		lst_ptr_t free_tail;
		lst_ptr_t uncomp_head;
		lst_ptr_t uncomp_tail;
	} tol_ht_t;

	// move one entry between lists
	typedef struct packed {
		logic       req;       // update strobe
		att_id_t    att_id;
		lst_ptr_t   lst_id;
		list_sel_e  src_list;
		list_sel_e  dst_list;
		lst_entry_t entry;     // copy of the moved list entry
	} tbl_upd_t;

	typedef enum logic [2:0] {
		KIND_ATT_INIT,
		KIND_LST_INIT,
		KIND_ATT_UPD,
		KIND_POP_HEAD,   // new head gets the popped prev
		KIND_PUSH_TAIL,  // own prev and next
		KIND_LINK_TAIL   // old tail next
	} wr_kind_e;

	// head/tail register update strobes
	typedef struct packed {
		logic lst_init;  // free list built
		logic exhaust;   // last free entry taken
		logic pop;       // free head advances
		logic push;      // uncompressed tail moves
	} ht_upd_t;

endpackage

`default_nettype wire

// ==== src/pgwr_bus_pkg.sv ====
// write bus types for the page-table write manager
// one full line per request, addr/data strobes and posted responses
`default_nettype none
`include "pgwr_consts.svh"

package pgwr_bus_pkg;

	typedef logic [63:0] addr_t;                       // byte address
	typedef logic [`PGWR_LINE_BYTES*8-1:0] data_t;     // one line
	typedef logic [`PGWR_LINE_BYTES-1:0] strb_t;       // byte enables
	typedef logic [1:0] bresp_t;                       // 0 is okay

	typedef struct packed {
		addr_t addr;
		data_t data;
		strb_t strb;
		logic  awvalid;  // one-cycle pulse
		logic  wvalid;   // one-cycle pulse
	} wr_req_t;

	typedef struct packed {
		logic awready;
		logic wready;
	} wr_rdy_t;

	typedef struct packed {
		logic   bvalid;
		bresp_t bresp;
	} wr_resp_t;

endpackage

`default_nettype wire

// ==== src/pgwr_seq_fsm.sv ====
// write sequencer for the page-table write manager
// runs ATT init, list init and table updates one write step at a time
`default_nettype none
`include "pgwr_consts.svh"

module pgwr_seq_fsm
	import pgwr_tbl_pkg::*;
	import pgwr_bus_pkg::*;
(
	input  logic     clk_i,
	input  logic     rst_ni,
	input  logic     init_att,
	input  logic     init_list,
	input  tbl_upd_t upd,
	input  wr_rdy_t  rdy,
	input  logic     all_resp,
	input  tol_ht_t  tol_ht,
	input  addr_t    fmt_addr,
	input  data_t    fmt_data,
	input  strb_t    fmt_strb,
	output wr_kind_e kind,
	output lst_ptr_t entry_cnt,
	output tbl_upd_t upd_q,
	output wr_req_t  req,
	output ht_upd_t  ht_upd,
	output logic     init_att_done,
	output logic     init_list_done,
	output logic     mngr_ready,
	output logic     upd_done
);

	typedef enum logic [3:0] {
		ST_IDLE,
		ST_INIT_ATT, ST_WAIT_ATT,
		ST_INIT_LST, ST_WAIT_LST,
		ST_ATT_UPD,  ST_ATT_WAIT,
		ST_SRC_UPD,  ST_SRC_WAIT,
		ST_DST_UPD,  ST_DST_WAIT,
		ST_RESP_WAIT
	} state_e;

	state_e   state_q, state_d;
	lst_ptr_t cnt_q, cnt_d;      // entry id during init
	logic     link_q, link_d;    // second destination write pending
	logic     aw_q, aw_d;
	logic     w_q, w_d;
	logic     att_done_set, lst_done_set;
	logic     upd_load;
	logic     aw_go, w_go;
	logic     free_last;
	addr_t    addr_q;
	data_t    data_q;
	strb_t    strb_q;

	// a ready counts only when our own pulse is not on the bus
	assign aw_go = rdy.awready && !aw_q;
	assign w_go  = rdy.wready && !w_q;
	assign free_last = (tol_ht.free_head == tol_ht.free_tail);  // also true when empty

	always_comb begin
		state_d      = state_q;
		cnt_d        = cnt_q;
		link_d       = link_q;
		aw_d         = 1'b0;  // valids are single pulses
		w_d          = 1'b0;
		att_done_set = 1'b0;
		lst_done_set = 1'b0;
		upd_load     = 1'b0;
		ht_upd       = '0;
		case (state_q)
			ST_IDLE: begin
				if (init_att && !init_att_done) begin
					state_d = ST_INIT_ATT;
					cnt_d   = lst_ptr_t'(1);
				end else if (init_list && !init_list_done) begin
					state_d = ST_INIT_LST;
					cnt_d   = lst_ptr_t'(1);
				end else if (upd.req) begin
					state_d  = ST_ATT_UPD;
					upd_load = 1'b1;  // freeze the request
					link_d   = 1'b0;
				end
			end
			ST_INIT_ATT: begin
				if (aw_go) begin
					if (cnt_q <= lst_ptr_t'(`PGWR_ATT_ENTRY_CNT)) begin
						aw_d    = 1'b1;
						cnt_d   = cnt_q + 1'b1;
						state_d = ST_WAIT_ATT;
					end else begin
						att_done_set = 1'b1;  // all entries written
						state_d      = ST_IDLE;
					end
				end
			end
			ST_WAIT_ATT: begin
				if (w_go) begin
					w_d     = 1'b1;
					state_d = ST_INIT_ATT;
				end
			end
			ST_INIT_LST: begin
				if (aw_go) begin
					if (cnt_q <= lst_ptr_t'(`PGWR_LIST_ENTRY_CNT)) begin
						aw_d    = 1'b1;
						cnt_d   = cnt_q + 1'b1;
						state_d = ST_WAIT_LST;
					end else begin
						lst_done_set    = 1'b1;
						ht_upd.lst_init = 1'b1;  // free list spans 1..count
						state_d         = ST_IDLE;
					end
				end
			end
			ST_WAIT_LST: begin
				if (w_go) begin
					w_d     = 1'b1;
					state_d = ST_INIT_LST;
				end
			end
			ST_ATT_UPD: begin
				if (aw_go) begin
					aw_d    = 1'b1;
					state_d = ST_ATT_WAIT;
				end
			end
			ST_ATT_WAIT: begin
				if (w_go) begin
					w_d = 1'b1;
					if (upd_q.src_list != LST_FREE) begin
						state_d = ST_DST_UPD;
					end else if (free_last) begin
						ht_upd.exhaust = 1'b1;  // no pop, list goes empty
						state_d        = ST_DST_UPD;
					end else begin
						state_d = ST_SRC_UPD;
					end
				end
			end
			ST_SRC_UPD: begin
				if (aw_go) begin
					aw_d    = 1'b1;
					state_d = ST_SRC_WAIT;
				end
			end
			ST_SRC_WAIT: begin
				if (w_go) begin
					w_d        = 1'b1;
					ht_upd.pop = 1'b1;
					state_d    = ST_DST_UPD;
				end
			end
			ST_DST_UPD: begin
				if (aw_go) begin
					aw_d    = 1'b1;
					state_d = ST_DST_WAIT;
				end
			end
			ST_DST_WAIT: begin
				if (w_go) begin
					w_d = 1'b1;
					if (!link_q && (tol_ht.uncomp_tail != '0)) begin
						link_d  = 1'b1;  // old tail still needs its next
						state_d = ST_DST_UPD;
					end else begin
						ht_upd.push = 1'b1;
						state_d     = ST_RESP_WAIT;
					end
				end
			end
			ST_RESP_WAIT: begin
				if (all_resp) state_d = ST_IDLE;
			end
			default: state_d = ST_IDLE;
		endcase
	end

	// formatter selection follows the issuing state
	always_comb begin
		case (state_q)
			ST_INIT_LST: kind = KIND_LST_INIT;
			ST_ATT_UPD:  kind = KIND_ATT_UPD;
			ST_SRC_UPD:  kind = KIND_POP_HEAD;
			ST_DST_UPD:  kind = link_q ? KIND_LINK_TAIL : KIND_PUSH_TAIL;
			default:     kind = KIND_ATT_INIT;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q        <= ST_IDLE;
			cnt_q          <= '0;
			link_q         <= 1'b0;
			aw_q           <= 1'b0;
			w_q            <= 1'b0;
			init_att_done  <= 1'b0;
			init_list_done <= 1'b0;
		end else begin
			state_q <= state_d;
			cnt_q   <= cnt_d;
			link_q  <= link_d;
			aw_q    <= aw_d;
			w_q     <= w_d;
			if (att_done_set) init_att_done <= 1'b1;   // sticky
			if (lst_done_set) init_list_done <= 1'b1;
		end
	end

	always_ff @(posedge clk_i) begin
		if (aw_d) begin  // line captured with the address pulse
			addr_q <= fmt_addr;
			data_q <= fmt_data;
			strb_q <= fmt_strb;
		end
		if (upd_load) upd_q <= upd;
	end

	assign req = '{addr: addr_q, data: data_q, strb: strb_q, awvalid: aw_q, wvalid: w_q};
	assign entry_cnt  = cnt_q;
	assign mngr_ready = (state_q == ST_IDLE);
	assign upd_done   = (state_q == ST_RESP_WAIT) && all_resp;

	// address and data pulses of one step are always in different cycles
	a_aw_w_apart: assert property (@(posedge clk_i) disable iff (!rst_ni)
		!(req.awvalid && req.wvalid));

endmodule

`default_nettype wire

// ==== src/pgwr_line_formatter.sv ====
// line formatter for table writes
// places one entry or pointer field in its line and enables only its bytes
`default_nettype none
`include "pgwr_consts.svh"

module pgwr_line_formatter
	import pgwr_tbl_pkg::*;
	import pgwr_bus_pkg::*;
(
	input  wr_kind_e kind,
	input  lst_ptr_t entry_cnt,
	input  tbl_upd_t upd_q,
	input  tol_ht_t  tol_ht,
	output addr_t    addr,
	output data_t    data,
	output strb_t    strb
);

	localparam int ATT_LN_W = $clog2(`PGWR_ATT_PER_LINE);
	localparam int LST_LN_W = $clog2(`PGWR_LST_PER_LINE);
	localparam int ATT_BITS = $bits(att_entry_t);
	localparam int LST_BITS = $bits(lst_entry_t);

	lst_ptr_t            tbl_id;    // id of the entry this write touches
	logic                att_tbl;
	lst_ptr_t            id_m1;
	lst_ptr_t            line_idx;
	logic [ATT_LN_W-1:0] att_lane;
	logic [LST_LN_W-1:0] lst_lane;
	att_entry_t          att_e;
	lst_entry_t          lst_e;

	always_comb begin
		case (kind)
			KIND_ATT_UPD:   tbl_id = upd_q.att_id;
			KIND_POP_HEAD:  tbl_id = upd_q.entry.next;    // new free head
			KIND_PUSH_TAIL: tbl_id = upd_q.lst_id;
			KIND_LINK_TAIL: tbl_id = tol_ht.uncomp_tail;  // tail before the push
			default:        tbl_id = entry_cnt;           // init runs
		endcase
	end

	assign att_tbl  = (kind == KIND_ATT_INIT) || (kind == KIND_ATT_UPD);
	assign id_m1    = tbl_id - 1'b1;  // ids start at 1
	assign att_lane = id_m1[ATT_LN_W-1:0];
	assign lst_lane = id_m1[LST_LN_W-1:0];
	assign line_idx = att_tbl ? (id_m1 >> ATT_LN_W) : (id_m1 >> LST_LN_W);

	assign addr = (att_tbl ? addr_t'(`PGWR_ATT_BASE) : addr_t'(`PGWR_LIST_BASE))
		+ addr_t'(line_idx) * addr_t'(`PGWR_LINE_BYTES);

	always_comb begin
		data  = '0;
		strb  = '0;
		att_e = '{count: '0, way: '0, sts: STS_DALLOC};
		lst_e = '0;
		case (kind)
			KIND_ATT_INIT: begin
				data[att_lane*ATT_BITS +: ATT_BITS] = att_e;  // deallocated, way 0
				strb[att_lane*8 +: 8] = '1;
			end
			KIND_ATT_UPD: begin
				att_e.way = upd_q.entry.way;  // list way becomes the ATT way
				att_e.sts = (upd_q.dst_list == LST_UNCOMP) ? STS_UNCOMP : STS_COMP;
				data[att_lane*ATT_BITS +: ATT_BITS] = att_e;
				strb[att_lane*8 +: 8] = '1;
			end
			KIND_LST_INIT: begin
				lst_e.way  = way_t'(`PGWR_PPA_BASE) + way_t'(id_m1);
				lst_e.prev = id_m1;  // entry 1 gets null
				lst_e.next = (entry_cnt == lst_ptr_t'(`PGWR_LIST_ENTRY_CNT)) ?
					'0 : entry_cnt + 1'b1;
				data[lst_lane*LST_BITS +: LST_BITS] = lst_e;
				strb[lst_lane*16 +: 16] = '1;
			end
			KIND_POP_HEAD: begin
				// prev word of the new head
				data[lst_lane*LST_BITS+32 +: 32] = upd_q.entry.prev;
				strb[lst_lane*16+4 +: 4] = '1;
			end
			KIND_PUSH_TAIL: begin
				lst_e.prev = tol_ht.uncomp_tail;  // null when list was empty
				lst_e.next = '0;
				data[lst_lane*LST_BITS +: 64] = {lst_e.prev, lst_e.next};
				strb[lst_lane*16 +: 8] = '1;
			end
			KIND_LINK_TAIL: begin
				data[lst_lane*LST_BITS +: 32] = upd_q.lst_id;  // next word only
				strb[lst_lane*16 +: 4] = '1;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== src/tol_ht_regs.sv ====
// list head and tail registers
// applies the sequencer strobes to the free and uncompressed list pointers
`default_nettype none

module tol_ht_regs
	import pgwr_tbl_pkg::*;
(
	input  logic     clk_i,
	input  logic     rst_ni,
	input  ht_upd_t  ht_upd,
	input  tbl_upd_t upd_q,
	input  lst_ptr_t entry_cnt,
	output tol_ht_t  tol_ht
);

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			tol_ht <= '0;  // all lists empty
		end else begin
			if (ht_upd.lst_init) begin
				tol_ht.free_head <= lst_ptr_t'(1);
				tol_ht.free_tail <= entry_cnt - 1'b1;  // counter ran one past the last
			end
			if (ht_upd.exhaust) begin
				tol_ht.free_head <= '0;
				tol_ht.free_tail <= '0;
			end
			if (ht_upd.pop) tol_ht.free_head <= upd_q.entry.next;
			if (ht_upd.push) begin
				tol_ht.uncomp_tail <= upd_q.lst_id;
				// first entry is head as well
				if (tol_ht.uncomp_tail == '0) tol_ht.uncomp_head <= upd_q.lst_id;
			end
		end
	end

	// a list is either empty on both ends or on neither
	a_ht_null_pair: assert property (@(posedge clk_i) disable iff (!rst_ni)
		((tol_ht.free_head == '0) == (tol_ht.free_tail == '0)) &&
		((tol_ht.uncomp_head == '0) == (tol_ht.uncomp_tail == '0)));

endmodule

`default_nettype wire

// ==== src/wr_resp_tracker.sv ====
// write response tracker
// counts outstanding writes and flags error or unexpected responses
`default_nettype none

module wr_resp_tracker
	import pgwr_bus_pkg::*;
(
	input  logic     clk_i,
	input  logic     rst_ni,
	input  wr_req_t  req,
	input  wr_rdy_t  rdy,
	input  wr_resp_t resp,
	output logic     all_resp,
	output logic     bus_error
);

	localparam int MAX_OUT = 64;  // lines in flight
	localparam int CNT_W   = $clog2(MAX_OUT + 1);

	logic [CNT_W-1:0] out_cnt;
	logic             aw_fire;
	logic             stray_b;  // response with nothing in flight

	assign aw_fire = req.awvalid && rdy.awready;
	assign stray_b = resp.bvalid && !aw_fire && (out_cnt == '0);

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			out_cnt   <= '0;
			bus_error <= 1'b0;
		end else begin
			case ({aw_fire, resp.bvalid})
				2'b10: out_cnt <= out_cnt + 1'b1;
				2'b01: if (out_cnt != '0) out_cnt <= out_cnt - 1'b1;
				default: ;  // both or neither leaves the count
			endcase
			if (stray_b || (resp.bvalid && (resp.bresp != '0)))
				bus_error <= 1'b1;  // sticky until reset
		end
	end

	assign all_resp = (out_cnt == '0);

	a_out_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
		out_cnt <= CNT_W'(MAX_OUT));

endmodule

`default_nettype wire

// ==== src/hawk_pgwr_mngr.sv ====
// page-table write manager top level
// initializes the ATT and list tables and moves entries between lists
`default_nettype none

module hawk_pgwr_mngr
	import pgwr_tbl_pkg::*;
	import pgwr_bus_pkg::*;
(
	input  logic     clk_i,
	input  logic     rst_ni,
	input  logic     init_att,
	input  logic     init_list,
	input  tbl_upd_t upd,
	output wr_req_t  req,
	input  wr_rdy_t  rdy,
	input  wr_resp_t resp,
	output tol_ht_t  tol_ht,
	output logic     init_att_done,
	output logic     init_list_done,
	output logic     mngr_ready,
	output logic     upd_done,
	output logic     bus_error
);

	wr_kind_e kind;
	lst_ptr_t entry_cnt;
	tbl_upd_t upd_q;       // request held for the whole update
	ht_upd_t  ht_upd;
	addr_t    fmt_addr;
	data_t    fmt_data;
	strb_t    fmt_strb;
	logic     all_resp;

	pgwr_seq_fsm pgwr_seq_fsm_i (
		.clk_i          (clk_i),
		.rst_ni         (rst_ni),
		.init_att       (init_att),
		.init_list      (init_list),
		.upd            (upd),
		.rdy            (rdy),
		.all_resp       (all_resp),
		.tol_ht         (tol_ht),
		.fmt_addr       (fmt_addr),
		.fmt_data       (fmt_data),
		.fmt_strb       (fmt_strb),
		.kind           (kind),
		.entry_cnt      (entry_cnt),
		.upd_q          (upd_q),
		.req            (req),
		.ht_upd         (ht_upd),
		.init_att_done  (init_att_done),
		.init_list_done (init_list_done),
		.mngr_ready     (mngr_ready),
		.upd_done       (upd_done)
	);

	pgwr_line_formatter pgwr_line_formatter_i (
		.kind      (kind),
		.entry_cnt (entry_cnt),
		.upd_q     (upd_q),
		.tol_ht    (tol_ht),
		.addr      (fmt_addr),
		.data      (fmt_data),
		.strb      (fmt_strb)
	);

	tol_ht_regs tol_ht_regs_i (
		.clk_i     (clk_i),
		.rst_ni    (rst_ni),
		.ht_upd    (ht_upd),
		.upd_q     (upd_q),
		.entry_cnt (entry_cnt),
		.tol_ht    (tol_ht)
	);

	wr_resp_tracker wr_resp_tracker_i (
		.clk_i     (clk_i),
		.rst_ni    (rst_ni),
		.req       (req),
		.rdy       (rdy),
		.resp      (resp),
		.all_resp  (all_resp),
		.bus_error (bus_error)
	);

endmodule

`default_nettype wire

// ==== tests/pgwr_checker.sv ====
// scoreboard for the page-table write manager
// predicts each table write and the list heads and tails, compares at every done
`default_nettype none
`include "pgwr_consts.svh"

module pgwr_checker
	import pgwr_tbl_pkg::*;
	import pgwr_bus_pkg::*;
(
	input  logic       clk_i,
	input  logic       rst_ni,
	input  logic       init_att,
	input  logic       init_list,
	input  tbl_upd_t   upd,
	input  wr_req_t    req,
	input  wr_resp_t   resp,
	input  tol_ht_t    tol_ht,
	input  logic       init_att_done,
	input  logic       init_list_done,
	input  logic       mngr_ready,
	input  logic       upd_done,
	input  logic       bus_error,
	input  logic [7:0] exp_writes,  // write count the running row must give
	output int         err_cnt,
	output int         chk_cnt
);
	timeunit 1ns;
	timeprecision 1ps;

	typedef struct packed {
		addr_t addr;
		strb_t strb;
		data_t data;  // expected field, zero outside the strobe
	} wr_exp_t;

	wr_exp_t     exp_q[$];
	tol_ht_t     ht_m;        // model of the four list pointers
	int unsigned wr_seen;
	int unsigned out_m;       // writes still waiting for a response
	int unsigned aw_open;     // address pulses still waiting for their data pulse
	logic        err_m;
	logic        att_done_q, lst_done_q;
	logic        upd_done_q;

	task automatic compare_val(input string name, input logic [511:0] got,
		input logic [511:0] exp);
		chk_cnt++;
		if (got !== exp) begin
			$display("FAIL %s got %0h exp %0h", name, got, exp);
			err_cnt++;
		end
	endtask

	// queue one write of nbytes taken from val, off bytes into entry id
	task automatic expect_write(input addr_t base, input int unsigned id,
		input int unsigned per_line, input int unsigned ent_bytes,
		input int unsigned off, input int unsigned nbytes, input logic [127:0] val);
		wr_exp_t     w;
		int unsigned pos;
		int unsigned b;
		w.addr = base + addr_t'((id - 1) / per_line) * `PGWR_LINE_BYTES;
		w.strb = '0;
		w.data = '0;
		pos = ((id - 1) % per_line) * ent_bytes + off;  // lane start plus field offset
		for (b = 0; b < nbytes; b++) begin
			w.strb[pos + b] = 1'b1;
			w.data[(pos + b) * 8 +: 8] = val[b * 8 +: 8];
		end
		exp_q.push_back(w);
	endtask

	task automatic start_att_init();
		att_entry_t  a;
		int unsigned n;
		a = '{count: '0, way: '0, sts: STS_DALLOC};
		for (n = 1; n <= `PGWR_ATT_ENTRY_CNT; n++)
			expect_write(`PGWR_ATT_BASE, n, `PGWR_ATT_PER_LINE, 8, 0, 8, {64'b0, a});
		wr_seen = 0;
	endtask

	task automatic start_lst_init();
		lst_entry_t  e;
		int unsigned n;
		for (n = 1; n <= `PGWR_LIST_ENTRY_CNT; n++) begin
			e.rsvd = '0;
			e.way  = way_t'(`PGWR_PPA_BASE) + way_t'(n - 1);
			e.prev = lst_ptr_t'(n - 1);  // null for the first entry
			e.next = (n == `PGWR_LIST_ENTRY_CNT) ? '0 : lst_ptr_t'(n + 1);
			expect_write(`PGWR_LIST_BASE, n, `PGWR_LST_PER_LINE, 16, 0, 16, e);
		end
		ht_m.free_head = lst_ptr_t'(1);
		ht_m.free_tail = lst_ptr_t'(`PGWR_LIST_ENTRY_CNT);
		wr_seen = 0;
	endtask

	// free head moves to the tail of the uncompressed list
	task automatic start_update(input tbl_upd_t u);
		att_entry_t a;
		lst_ptr_t   old_tail;
		a = '{count: '0, way: u.entry.way, sts: STS_UNCOMP};
		expect_write(`PGWR_ATT_BASE, u.att_id, `PGWR_ATT_PER_LINE, 8, 0, 8, {64'b0, a});
		if (ht_m.free_head != ht_m.free_tail) begin
			// new free head inherits the prev word
			expect_write(`PGWR_LIST_BASE, u.entry.next, `PGWR_LST_PER_LINE, 16, 4, 4,
				{96'b0, u.entry.prev});
			ht_m.free_head = u.entry.next;
		end else begin
			ht_m.free_head = '0;  // last free entry taken
			ht_m.free_tail = '0;
		end
		old_tail = ht_m.uncomp_tail;
		expect_write(`PGWR_LIST_BASE, u.lst_id, `PGWR_LST_PER_LINE, 16, 0, 8,
			{64'b0, old_tail, 32'b0});
		if (old_tail != '0)
			expect_write(`PGWR_LIST_BASE, old_tail, `PGWR_LST_PER_LINE, 16, 0, 4,
				{96'b0, u.lst_id});
		else
			ht_m.uncomp_head = u.lst_id;
		ht_m.uncomp_tail = u.lst_id;
		wr_seen = 0;
	endtask

	task automatic check_write();
		wr_exp_t w;
		data_t   mask;
		int      b;
		wr_seen++;
		if (exp_q.size() == 0) begin
			$display("unexpected write to address %0h while no write was due", req.addr);
			err_cnt++;
			return;
		end
		w = exp_q.pop_front();
		for (b = 0; b < `PGWR_LINE_BYTES; b++)
			mask[b * 8 +: 8] = {8{w.strb[b]}};
		compare_val("req.addr", req.addr, w.addr);
		compare_val("req.strb", req.strb, w.strb);
		compare_val("req.data", req.data & mask, w.data);  // written bytes only
	endtask

	task automatic check_done(input string what);
		if (exp_q.size() != 0) begin
			$display("%0d predicted writes never came before %s", exp_q.size(), what);
			err_cnt++;
			exp_q.delete();
		end
		compare_val("write count", wr_seen, exp_writes);
		compare_val("open address pulses", aw_open, 0);  // every address got its data
		compare_val("tol_ht", tol_ht, ht_m);
	endtask

	always @(posedge clk_i) begin
		if (!rst_ni) begin
			exp_q.delete();
			ht_m       = '0;  // every list empty
			wr_seen    = 0;
			out_m      = 0;
			aw_open    = 0;
			err_m      = 1'b0;
			err_cnt    = 0;
			chk_cnt    = 0;
			att_done_q = 1'b0;
			lst_done_q = 1'b0;
			upd_done_q = 1'b0;
		end else begin
			// busy while writes are due, idle again right after an update ends
			if (exp_q.size() != 0) compare_val("mngr_ready", mngr_ready, 1'b0);
			if (upd_done_q) compare_val("mngr_ready", mngr_ready, 1'b1);
			if (mngr_ready && init_att && !init_att_done) start_att_init();
			else if (mngr_ready && init_list && !init_list_done) start_lst_init();
			else if (mngr_ready && upd.req) start_update(upd);
			if (req.awvalid) check_write();
			if (req.wvalid) begin
				if (aw_open == 0) begin
					$display("data pulse seen with no address pulse before it");
					err_cnt++;
				end else begin
					aw_open--;
				end
			end
			if (req.awvalid) aw_open++;
			if (init_att_done && !att_done_q) check_done("init_att_done");
			if (init_list_done && !lst_done_q) check_done("init_list_done");
			if (upd_done) check_done("upd_done");
			compare_val("bus_error", bus_error, err_m);
			// error response or a response with nothing in flight
			if (resp.bvalid && (resp.bresp != 2'b00 || (out_m == 0 && !req.awvalid)))
				err_m = 1'b1;
			if (req.awvalid) out_m++;
			if (resp.bvalid && out_m != 0) out_m--;
			att_done_q = init_att_done;
			lst_done_q = init_list_done;
			upd_done_q = upd_done;
		end
	end

endmodule

`default_nettype wire

// ==== tests/tb_hawk_pgwr_mngr.sv ====
// testbench for the page-table write manager
// runs an operation table against a write sink with random ready stalls
`default_nettype none
`include "pgwr_consts.svh"

module tb_hawk_pgwr_mngr
	import pgwr_tbl_pkg::*;
	import pgwr_bus_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	typedef enum logic [1:0] {OP_INIT_ATT, OP_INIT_LST, OP_UPD, OP_UPD_ERR} op_e;

	typedef struct packed {
		op_e        op;
		att_id_t    att_id;
		lst_ptr_t   lst_id;
		lst_ptr_t   next;   // next pointer of the moved entry
		logic [7:0] n_wr;   // writes the row must produce
	} row_t;

	localparam int N_ROWS  = 10;
	localparam int TIMEOUT = N_ROWS * 200;

	// free entries 1..8 move to the uncompressed list, the last one drains the free list
	localparam row_t ROWS [N_ROWS] = '{
		'{OP_INIT_ATT, 32'd0,  32'd0, 32'd0, 8'd16},
		'{OP_INIT_LST, 32'd0,  32'd0, 32'd0, 8'd8},
		'{OP_UPD,      32'd3,  32'd1, 32'd2, 8'd3},  // uncompressed list empty
		'{OP_UPD,      32'd10, 32'd2, 32'd3, 8'd4},
		'{OP_UPD,      32'd16, 32'd3, 32'd4, 8'd4},
		'{OP_UPD,      32'd1,  32'd4, 32'd5, 8'd4},
		'{OP_UPD,      32'd9,  32'd5, 32'd6, 8'd4},
		'{OP_UPD,      32'd4,  32'd6, 32'd7, 8'd4},
		'{OP_UPD,      32'd12, 32'd7, 32'd8, 8'd4},
		'{OP_UPD_ERR,  32'd8,  32'd8, 32'd0, 8'd3}   // free head equals tail
	};

	logic        clk_i;
	logic        rst_ni;
	logic        init_att;
	logic        init_list;
	tbl_upd_t    upd;
	wr_req_t     req;
	wr_rdy_t     rdy = '0;
	wr_resp_t    resp = '0;
	tol_ht_t     tol_ht;
	logic        init_att_done, init_list_done, mngr_ready, upd_done, bus_error;
	logic [7:0]  exp_writes;
	int          chk_err, chk_cnt;
	int          rows_run = 0;
	int unsigned cyc = 0;
	int unsigned due_q[$];     // cycle numbers of pending responses
	int          err_armed = 0;
	int          err_sent = 0;
	logic [31:0] rng_state = 32'd44;
	logic [31:0] rnd;

	hawk_pgwr_mngr hawk_pgwr_mngr_i (
		.clk_i          (clk_i),
		.rst_ni         (rst_ni),
		.init_att       (init_att),
		.init_list      (init_list),
		.upd            (upd),
		.req            (req),
		.rdy            (rdy),
		.resp           (resp),
		.tol_ht         (tol_ht),
		.init_att_done  (init_att_done),
		.init_list_done (init_list_done),
		.mngr_ready     (mngr_ready),
		.upd_done       (upd_done),
		.bus_error      (bus_error)
	);

	pgwr_checker pgwr_checker_i (
		.clk_i          (clk_i),
		.rst_ni         (rst_ni),
		.init_att       (init_att),
		.init_list      (init_list),
		.upd            (upd),
		.req            (req),
		.resp           (resp),
		.tol_ht         (tol_ht),
		.init_att_done  (init_att_done),
		.init_list_done (init_list_done),
		.mngr_ready     (mngr_ready),
		.upd_done       (upd_done),
		.bus_error      (bus_error),
		.exp_writes     (exp_writes),
		.err_cnt        (chk_err),
		.chk_cnt        (chk_cnt)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	initial begin
		clk_i = 1'b0;
		forever #4 clk_i = ~clk_i;
	end

	// write sink, takes every valid pulse
	always @(posedge clk_i) begin
		rnd = xorshift32(rng_state);
		rng_state = rnd;
		if (!rst_ni) begin
			rdy  <= '0;
			resp <= '0;
		end else begin
			// awready stays up until the address pulse it allowed has gone by
			if (!rdy.awready) rdy.awready <= (rnd[1:0] != 2'b00);
			else if (req.awvalid) rdy.awready <= rnd[2];
			rdy.wready <= (rnd[4:3] != 2'b00);
			if (req.awvalid) due_q.push_back(cyc + 2 + rnd[6:5]);
			if (due_q.size() > 0 && due_q[0] <= cyc) begin
				void'(due_q.pop_front());
				resp.bvalid <= 1'b1;
				if (err_sent != err_armed) begin
					resp.bresp <= 2'b10;  // slave error
					err_sent   <= err_sent + 1;
				end else begin
					resp.bresp <= 2'b00;
				end
			end else begin
				resp <= '0;
			end
		end
	end

	always @(posedge clk_i) begin
		cyc <= cyc + 1;
		if (cyc >= TIMEOUT) begin
			$display("timeout, the run did not finish within %0d cycles", TIMEOUT);
			$display("Done: errors found");
			$finish;
		end
	end

	task automatic apply_row(input row_t row);
		tbl_upd_t u;
		@(posedge clk_i);
		while (!mngr_ready) @(posedge clk_i);
		u            = '0;
		u.req        = 1'b1;
		u.att_id     = row.att_id;
		u.lst_id     = row.lst_id;
		u.src_list   = LST_FREE;
		u.dst_list   = LST_UNCOMP;
		u.entry.way  = way_t'(`PGWR_PPA_BASE) + way_t'(row.lst_id - 1);
		u.entry.prev = '0;  // a free head always has a null prev
		u.entry.next = row.next;
		exp_writes <= row.n_wr;
		case (row.op)
			OP_INIT_ATT: init_att <= 1'b1;
			OP_INIT_LST: init_list <= 1'b1;
			OP_UPD_ERR: begin
				err_armed <= err_armed + 1;  // first response of this update fails
				upd       <= u;
			end
			default: upd <= u;
		endcase
		@(posedge clk_i);  // idle FSM takes the request here
		init_att  <= 1'b0;
		init_list <= 1'b0;
		upd.req   <= 1'b0;
		case (row.op)
			OP_INIT_ATT: while (!init_att_done) @(posedge clk_i);
			OP_INIT_LST: while (!init_list_done) @(posedge clk_i);
			default:     while (!upd_done) @(posedge clk_i);
		endcase
		rows_run++;
	endtask

	initial begin
		int i;
		rst_ni     = 1'b0;
		init_att   = 1'b0;
		init_list  = 1'b0;
		upd        = '0;
		exp_writes = '0;
		repeat (2) @(posedge clk_i);
		rst_ni <= 1'b1;
		for (i = 0; i < N_ROWS; i++)
			apply_row(ROWS[i]);
		repeat (8) @(posedge clk_i);  // let the last responses drain
		$display("%0d rows run, %0d checks, %0d errors", rows_run, chk_cnt, chk_err);
		if (chk_err == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+include
src/pgwr_tbl_pkg.sv
src/pgwr_bus_pkg.sv
src/pgwr_seq_fsm.sv
src/pgwr_line_formatter.sv
src/tol_ht_regs.sv
src/wr_resp_tracker.sv
src/hawk_pgwr_mngr.sv
tests/pgwr_checker.sv
tests/tb_hawk_pgwr_mngr.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and scan the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f vlog.f \
	--top-module tb_hawk_pgwr_mngr -o tb_sim \
	&& ./obj_dir/tb_sim > sim.log 2>&1 \
	|| { echo "build or simulation failed"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "Done: errors found" sim.log && exit 1
exit 0
